// File: pat_arch_pkg.sv
package pat_arch_pkg;

	// ========================================
	// datapath widths
	// ========================================
	localparam int DATA_W   = 8;  // accumulator and field word
	localparam int IADDR_W  = 10; // instruction address space
	localparam int INSTR_W  = 20; // one instruction word
	localparam int DADDR_W  = 3;  // data memory address
	localparam int FIELDP_W = 5;
	localparam int BUFP_W   = 3;
	localparam int IMM3_W   = 3;  // shift amount / i3 immediate

	// sizing
	localparam int FIELD_LATENCY = 4; // cycles from field read to field write
	localparam int FLUSH_LEN     = 4; // slots squashed behind a taken branch
	localparam int DMEM_DEPTH    = 8;
	localparam int FLUSH_CNT_W   = $clog2(FLUSH_LEN);

	typedef logic [DATA_W-1:0]      data_t;
	typedef logic [IADDR_W-1:0]     iaddr_t;
	typedef logic [INSTR_W-1:0]     instr_t;
	typedef logic [DADDR_W-1:0]     daddr_t;
	typedef logic [FIELDP_W-1:0]    fieldp_t;
	typedef logic [BUFP_W-1:0]      bufp_t;
	typedef logic [IMM3_W-1:0]      imm3_t;
	typedef logic [FLUSH_CNT_W-1:0] flush_cnt_t;

endpackage

// File: pat_isa_pkg.sv
package pat_isa_pkg;

	// ========================================
	// instruction classes and opcodes
	// ========================================
	localparam logic [3:0] PREFIX = 4'b1111; // escapes i8 -> i3 and i3 -> i0

	// i8 space, bits 11..8
	localparam logic [3:0] OP_OR   = 4'b0000;
	localparam logic [3:0] OP_AND  = 4'b0001;
	localparam logic [3:0] OP_ADDM = 4'b0010;
	localparam logic [3:0] OP_SUBM = 4'b0011;
	localparam logic [3:0] OP_ADD  = 4'b0100;
	localparam logic [3:0] OP_SUB  = 4'b0101;
	localparam logic [3:0] OP_LDI  = 4'b0110;
	localparam logic [3:0] OP_LDM  = 4'b0111;
	localparam logic [3:0] OP_BF   = 4'b1000;
	localparam logic [3:0] OP_STM  = 4'b1011;
	localparam logic [3:0] OP_ORM  = 4'b1101;
	localparam logic [3:0] OP_ANDM = 4'b1110;

	// i3 space, bits 7..4
	localparam logic [3:0] OP_SHL  = 4'b0000;
	localparam logic [3:0] OP_SHLO = 4'b0001;
	localparam logic [3:0] OP_SHR  = 4'b0010;
	localparam logic [3:0] OP_ASR  = 4'b0011;
	localparam logic [3:0] OP_IN   = 4'b0101;
	localparam logic [3:0] OP_OUT  = 4'b1000;
	localparam logic [3:0] OP_SETB = 4'b1001;

	// i0 space, bits 3..0
	localparam logic [3:0] OP_NOT  = 4'b0000;
	localparam logic [3:0] OP_MOV  = 4'b0001;
	localparam logic [3:0] OP_TEST = 4'b0010;

	// double prefix with an unassigned i0 opcode, so no strobe fires
	localparam pat_arch_pkg::instr_t INSTR_NOP = 20'h06ff5;

	localparam int NUM_OPS     = 18; // one-hot strobes in the control word
	localparam int NUM_REG_OPS = 13; // leading strobes that write acc or field

	typedef enum logic [1:0] {COND_AL = 2'd0, COND_Z = 2'd1, COND_N = 2'd2} cond_t;

	typedef enum logic {ST_RUN, ST_FLUSH} exec_state_t;

endpackage

// File: pat_decode_if.sv
interface pat_decode_if;

	// one-hot op strobes, m forms already folded into or/and/add/sub
	logic op_or, op_and, op_add, op_sub;
	logic op_ldi, op_ldm, op_stm, op_bf;
	logic op_shl, op_shlo, op_shr, op_asr;
	logic op_in, op_out, op_setb;
	logic op_not, op_mov, op_test;

	logic field_op;           // instruction targets the field side
	logic dest_acc;
	logic dest_field;
	pat_isa_pkg::cond_t cond; // only bf looks at it
	pat_arch_pkg::data_t alu_b;     // memory operand or immediate, preselected
	pat_arch_pkg::data_t field_val; // low or high field input
	pat_arch_pkg::data_t imm;       // raw 8 bit immediate

	modport producer (
		output op_or, op_and, op_add, op_sub, op_ldi, op_ldm, op_stm, op_bf,
		output op_shl, op_shlo, op_shr, op_asr, op_in, op_out, op_setb,
		output op_not, op_mov, op_test,
		output field_op, dest_acc, dest_field, cond, alu_b, field_val, imm
	);

	modport consumer (
		input op_or, op_and, op_add, op_sub, op_ldi, op_ldm, op_stm, op_bf,
		input op_shl, op_shlo, op_shr, op_asr, op_in, op_out, op_setb,
		input op_not, op_mov, op_test,
		input field_op, dest_acc, dest_field, cond, alu_b, field_val, imm
	);

endinterface

// File: pat_alu.sv
module pat_alu (
	input  pat_arch_pkg::data_t i_a,
	input  pat_arch_pkg::data_t i_b,
	input  logic                i_op_or,
	input  logic                i_op_and,
	input  logic                i_op_not,
	input  logic                i_op_add,
	input  logic                i_op_sub,
	input  logic                i_op_shl,
	input  logic                i_op_shlo,
	input  logic                i_op_shr,
	input  logic                i_op_asr,
	output pat_arch_pkg::data_t o_y
);

	pat_arch_pkg::imm3_t sh;        // shift amount
	pat_arch_pkg::data_t shlo_fill; // ones in the vacated low bits

	assign sh = i_b[pat_arch_pkg::IMM3_W-1:0];
	assign shlo_fill = ~(pat_arch_pkg::data_t'('1) << sh);

	// strobes are one-hot, order only matters for idle cycles
	always_comb
	begin
		if (i_op_or)        o_y = i_a | i_b;
		else if (i_op_and)  o_y = i_a & i_b;
		else if (i_op_not)  o_y = ~i_a;
		else if (i_op_add)  o_y = i_a + i_b; // mod 256
		else if (i_op_sub)  o_y = i_a - i_b;
		else if (i_op_shl)  o_y = i_a << sh;
		else if (i_op_shlo) o_y = (i_a << sh) | shlo_fill;
		else if (i_op_shr)  o_y = i_a >> sh;
		else if (i_op_asr)  o_y = pat_arch_pkg::data_t'($signed(i_a) >>> sh);
		else                o_y = i_a; // pass through
	end

endmodule

// File: pat_data_mem.sv
module pat_data_mem (
	input  logic                 clk,
	input  pat_arch_pkg::daddr_t i_read_adr,
	input  pat_arch_pkg::daddr_t i_write_adr,
	input  logic                 i_write,
	input  pat_arch_pkg::data_t  i_data,
	output pat_arch_pkg::data_t  o_data
);

	pat_arch_pkg::data_t mem [pat_arch_pkg::DMEM_DEPTH];

	assign o_data = mem[i_read_adr]; // combinational read

	always_ff @(posedge clk)
	begin
		if (i_write)
			mem[i_write_adr] <= i_data;
	end

	a_wdata_known: assert property (@(posedge clk) i_write |-> !$isunknown(i_data));

endmodule

// File: pat_pc.sv
module pat_pc (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_jump,
	input  pat_arch_pkg::data_t  i_offset,
	output pat_arch_pkg::iaddr_t o_pc
);

	pat_arch_pkg::iaddr_t offset_ext;

	// relative offset, sign extended to the address width
	assign offset_ext = {{(pat_arch_pkg::IADDR_W - pat_arch_pkg::DATA_W)
		{i_offset[pat_arch_pkg::DATA_W-1]}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_jump)
			o_pc <= o_pc + offset_ext; // bf taken
		else
			o_pc <= o_pc + 1'b1;
	end

endmodule

// File: pat_decode.sv
module pat_decode (
	input  logic                    clk,
	input  logic                    reset,
	input  pat_arch_pkg::instr_t    i_instruction,
	input  pat_arch_pkg::data_t     i_field_in_low,
	input  pat_arch_pkg::data_t     i_field_in_high,
	input  logic                    i_high_side,
	input  pat_arch_pkg::data_t     i_mem_data,
	output pat_arch_pkg::daddr_t    o_mem_read_adr,
	output pat_arch_pkg::fieldp_t   o_fieldp,
	output pat_arch_pkg::fieldp_t   o_fieldwp,
	pat_decode_if.producer          ctl
);

	pat_arch_pkg::instr_t  ir; // instruction register
	pat_arch_pkg::fieldp_t ir_fieldp;
	logic [1:0]            ir_cond;
	logic                  ir_field_op;
	logic [3:0]            op8;
	pat_arch_pkg::data_t   imm8;
	pat_arch_pkg::imm3_t   imm3;
	logic                  is_i8, is_i3, is_i0;
	logic                  src_mem, dest_reg;
	pat_isa_pkg::cond_t    cond_d;
	pat_arch_pkg::data_t   imm_sel;
	logic [pat_isa_pkg::NUM_OPS-1:0] ops_d, ops_q;
	pat_arch_pkg::fieldp_t [pat_arch_pkg::FIELD_LATENCY-1:0] fieldp_hist;

	assign {ir_fieldp, ir_cond, ir_field_op, op8, imm8} = ir;
	assign imm3 = imm8[pat_arch_pkg::IMM3_W-1:0];

	// class select, i3 opcode is imm8[7:4] and i0 opcode is imm8[3:0]
	assign is_i8 = (op8 != pat_isa_pkg::PREFIX);
	assign is_i3 = !is_i8 && (imm8[7:4] != pat_isa_pkg::PREFIX);
	assign is_i0 = !is_i8 && !is_i3;

	// register-writing ops first, see NUM_REG_OPS
	assign ops_d = {
		is_i8 && (op8 == pat_isa_pkg::OP_OR  || op8 == pat_isa_pkg::OP_ORM),
		is_i8 && (op8 == pat_isa_pkg::OP_AND || op8 == pat_isa_pkg::OP_ANDM),
		is_i8 && (op8 == pat_isa_pkg::OP_ADD || op8 == pat_isa_pkg::OP_ADDM),
		is_i8 && (op8 == pat_isa_pkg::OP_SUB || op8 == pat_isa_pkg::OP_SUBM),
		is_i8 && (op8 == pat_isa_pkg::OP_LDI),
		is_i8 && (op8 == pat_isa_pkg::OP_LDM),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_SHL),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_SHLO),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_SHR),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_ASR),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_IN),
		is_i0 && (imm8[3:0] == pat_isa_pkg::OP_NOT),
		is_i0 && (imm8[3:0] == pat_isa_pkg::OP_MOV),
		is_i8 && (op8 == pat_isa_pkg::OP_STM),
		is_i8 && (op8 == pat_isa_pkg::OP_BF),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_OUT),
		is_i3 && (imm8[7:4] == pat_isa_pkg::OP_SETB),
		is_i0 && (imm8[3:0] == pat_isa_pkg::OP_TEST)
	};
	assign {ctl.op_or, ctl.op_and, ctl.op_add, ctl.op_sub, ctl.op_ldi, ctl.op_ldm,
		ctl.op_shl, ctl.op_shlo, ctl.op_shr, ctl.op_asr, ctl.op_in, ctl.op_not, ctl.op_mov,
		ctl.op_stm, ctl.op_bf, ctl.op_out, ctl.op_setb, ctl.op_test} = ops_q;

	assign dest_reg = |ops_d[pat_isa_pkg::NUM_OPS-1 -: pat_isa_pkg::NUM_REG_OPS];
	assign src_mem = is_i8 && (op8 == pat_isa_pkg::OP_LDM || op8 == pat_isa_pkg::OP_ADDM
		|| op8 == pat_isa_pkg::OP_SUBM || op8 == pat_isa_pkg::OP_ORM
		|| op8 == pat_isa_pkg::OP_ANDM);
	assign imm_sel = is_i8 ? imm8 : {{(pat_arch_pkg::DATA_W - pat_arch_pkg::IMM3_W){1'b0}}, imm3};
	assign o_mem_read_adr = imm8[pat_arch_pkg::DADDR_W-1:0]; // async read, sampled below
	assign o_fieldwp = fieldp_hist[pat_arch_pkg::FIELD_LATENCY-1];

	always_comb
	begin
		case (ir_cond)
			2'd1:    cond_d = pat_isa_pkg::COND_Z;
			2'd2:    cond_d = pat_isa_pkg::COND_N;
			default: cond_d = pat_isa_pkg::COND_AL; // 3 is treated as always
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ir             <= pat_isa_pkg::INSTR_NOP;
			ops_q          <= '0;
			ctl.field_op   <= 1'b0;
			ctl.dest_acc   <= 1'b0;
			ctl.dest_field <= 1'b0;
			ctl.cond       <= pat_isa_pkg::COND_AL;
			o_fieldp       <= '0;
			fieldp_hist    <= '0;
		end
		else
		begin
			ir             <= i_instruction;
			ops_q          <= ops_d;
			ctl.field_op   <= ir_field_op;
			ctl.dest_acc   <= dest_reg && !ir_field_op;
			ctl.dest_field <= dest_reg && ir_field_op;
			ctl.cond       <= cond_d;
			o_fieldp       <= ir_fieldp;
			fieldp_hist    <= {fieldp_hist[pat_arch_pkg::FIELD_LATENCY-2:0], o_fieldp};
		end
	end

	// operand preselect, keeps the muxes off the execute path
	always_ff @(posedge clk)
	begin
		ctl.alu_b     <= src_mem ? i_mem_data : imm_sel;
		ctl.field_val <= i_high_side ? i_field_in_high : i_field_in_low;
		ctl.imm       <= imm8;
	end

	// one strobe at most per word, so classes and opcodes never overlap
	a_one_class: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ops_d));

endmodule

// File: pat_execute.sv
module pat_execute (
	input  logic                  clk,
	input  logic                  reset,
	pat_decode_if.consumer        ctl,
	input  pat_arch_pkg::data_t   i_inputs,
	output logic                  o_high_side,
	output pat_arch_pkg::bufp_t   o_bufp,
	output pat_arch_pkg::data_t   o_field_out,
	output logic                  o_field_write_en_low,
	output logic                  o_field_write_en_high,
	output pat_arch_pkg::data_t   o_outputs,
	output logic                  o_mem_write,
	output pat_arch_pkg::daddr_t  o_mem_write_adr,
	output pat_arch_pkg::data_t   o_mem_write_data,
	output logic                  o_jump,
	output pat_arch_pkg::data_t   o_jump_offset
);

	pat_arch_pkg::data_t acc; // the accumulator
	pat_arch_pkg::data_t acc_alu_y, field_alu_y;
	pat_arch_pkg::data_t acc_result, field_result, test_val;
	logic z, n;               // set by test only
	logic high_side;          // 0 low buffer, 1 high buffer
	logic commit_en, cond_ok, take_bf;
	pat_isa_pkg::exec_state_t state;
	pat_arch_pkg::flush_cnt_t flush_cnt;

	// ========================================
	// two ALUs, acc side and field side
	// ========================================
	pat_alu u_acc_alu (
		.i_a(acc), .i_b(ctl.alu_b),
		.i_op_or(ctl.op_or), .i_op_and(ctl.op_and), .i_op_not(ctl.op_not),
		.i_op_add(ctl.op_add), .i_op_sub(ctl.op_sub),
		.i_op_shl(ctl.op_shl), .i_op_shlo(ctl.op_shlo), .i_op_shr(ctl.op_shr),
		.i_op_asr(ctl.op_asr), .o_y(acc_alu_y)
	);

	pat_alu u_field_alu (
		.i_a(ctl.field_val), .i_b(ctl.alu_b),
		.i_op_or(ctl.op_or), .i_op_and(ctl.op_and), .i_op_not(ctl.op_not),
		.i_op_add(ctl.op_add), .i_op_sub(ctl.op_sub),
		.i_op_shl(ctl.op_shl), .i_op_shlo(ctl.op_shlo), .i_op_shr(ctl.op_shr),
		.i_op_asr(ctl.op_asr), .o_y(field_alu_y)
	);

	// mov picks the other side as its source
	assign acc_result = (ctl.op_ldi || ctl.op_ldm) ? ctl.alu_b :
		ctl.op_in ? i_inputs : ctl.op_mov ? ctl.field_val : acc_alu_y;
	assign field_result = (ctl.op_ldi || ctl.op_ldm) ? ctl.alu_b :
		ctl.op_in ? i_inputs : ctl.op_mov ? acc : field_alu_y;
	assign test_val = ctl.field_op ? ctl.field_val : acc;

	assign commit_en = (state == pat_isa_pkg::ST_RUN); // squash while flushing

	always_comb
	begin
		case (ctl.cond)
			pat_isa_pkg::COND_Z: cond_ok = z;
			pat_isa_pkg::COND_N: cond_ok = n;
			default:             cond_ok = 1'b1;
		endcase
	end
	assign take_bf = commit_en && ctl.op_bf && cond_ok;

	// store goes straight to the memory, lands on the commit edge
	assign o_mem_write      = commit_en && ctl.op_stm;
	assign o_mem_write_adr  = ctl.imm[pat_arch_pkg::DADDR_W-1:0];
	assign o_mem_write_data = ctl.field_op ? ctl.field_val : acc;

	// forward a committing setb so the next instruction reads the new side
	assign o_high_side = (commit_en && ctl.op_setb) ? ctl.imm[pat_arch_pkg::BUFP_W] : high_side;

	// ========================================
	// commit and flush control
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state                 <= pat_isa_pkg::ST_RUN;
			flush_cnt             <= '0;
			acc                   <= '0;
			z                     <= 1'b0;
			n                     <= 1'b0;
			high_side             <= 1'b0;
			o_bufp                <= '0;
			o_outputs             <= '0;
			o_jump                <= 1'b0;
			o_field_write_en_low  <= 1'b0;
			o_field_write_en_high <= 1'b0;
		end
		else
		begin
			o_jump                <= take_bf; // one cycle pulse
			o_field_write_en_low  <= commit_en && ctl.dest_field && !high_side;
			o_field_write_en_high <= commit_en && ctl.dest_field && high_side;
			if (state == pat_isa_pkg::ST_FLUSH)
			begin
				if (flush_cnt == '0)
					state <= pat_isa_pkg::ST_RUN;
				else
					flush_cnt <= flush_cnt - 1'b1;
			end
			else if (take_bf)
			begin
				state     <= pat_isa_pkg::ST_FLUSH;
				flush_cnt <= pat_arch_pkg::flush_cnt_t'(pat_arch_pkg::FLUSH_LEN - 1);
			end
			if (commit_en)
			begin
				if (ctl.dest_acc)
					acc <= acc_result;
				if (ctl.op_out)
					o_outputs <= acc;
				if (ctl.op_setb)
				begin
					o_bufp    <= ctl.imm[pat_arch_pkg::BUFP_W-1:0];
					high_side <= ctl.imm[pat_arch_pkg::BUFP_W];
				end
				if (ctl.op_test)
				begin
					z <= (test_val == '0);
					n <= test_val[pat_arch_pkg::DATA_W-1]; // sign bit
				end
			end
		end
	end

	// payload, qualified by the strobes above
	always_ff @(posedge clk)
	begin
		if (commit_en && ctl.dest_field)
			o_field_out <= field_result;
		if (take_bf)
			o_jump_offset <= ctl.imm; // pc adds it on the next edge
	end

	// one enable at a time, on the side the operand was read from at decode
	a_we_exclusive: assert property (@(posedge clk) disable iff (reset)
		(o_field_write_en_low || o_field_write_en_high) |->
		!(o_field_write_en_low && o_field_write_en_high)
		&& (o_field_write_en_high == $past(o_high_side, 2)));

	// after a pulse the remaining flush slots stay quiet, then back to run
	a_no_jump_in_flush: assert property (@(posedge clk) disable iff (reset)
		o_jump |=> ((state == pat_isa_pkg::ST_FLUSH) && !o_jump)
		[*(pat_arch_pkg::FLUSH_LEN - 1)] ##1 (state == pat_isa_pkg::ST_RUN));

endmodule

// File: pat_core.sv
module pat_core (
	input  logic                  clk,
	input  logic                  reset,
	input  pat_arch_pkg::instr_t  i_instruction,
	input  pat_arch_pkg::data_t   i_field_in_low,
	input  pat_arch_pkg::data_t   i_field_in_high,
	input  pat_arch_pkg::data_t   i_inputs,
	output pat_arch_pkg::iaddr_t  o_pc,
	output logic                  o_jump,
	output pat_arch_pkg::bufp_t   o_bufp,
	output pat_arch_pkg::fieldp_t o_fieldp,
	output pat_arch_pkg::fieldp_t o_fieldwp,
	output logic                  o_field_write_en_low,
	output logic                  o_field_write_en_high,
	output pat_arch_pkg::data_t   o_field_out,
	output pat_arch_pkg::data_t   o_outputs
);

	logic                 high_side;
	pat_arch_pkg::daddr_t mem_read_adr;
	pat_arch_pkg::daddr_t mem_write_adr;
	pat_arch_pkg::data_t  mem_read_data;
	pat_arch_pkg::data_t  mem_write_data;
	logic                 mem_write;
	pat_arch_pkg::data_t  jump_offset;

	pat_decode_if ctl (); // decode to execute pipeline register

	// ========================================
	// stage 1, ir and decode
	// ========================================
	pat_decode u_decode (
		.clk(clk), .reset(reset),
		.i_instruction(i_instruction),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_high_side(high_side),
		.i_mem_data(mem_read_data), .o_mem_read_adr(mem_read_adr),
		.o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp),
		.ctl(ctl.producer)
	);

	pat_data_mem u_dmem (
		.clk(clk),
		.i_read_adr(mem_read_adr), .i_write_adr(mem_write_adr),
		.i_write(mem_write), .i_data(mem_write_data),
		.o_data(mem_read_data)
	);

	// ========================================
	// stage 2, execute and commit
	// ========================================
	pat_execute u_execute (
		.clk(clk), .reset(reset),
		.ctl(ctl.consumer),
		.i_inputs(i_inputs),
		.o_high_side(high_side), .o_bufp(o_bufp),
		.o_field_out(o_field_out),
		.o_field_write_en_low(o_field_write_en_low),
		.o_field_write_en_high(o_field_write_en_high),
		.o_outputs(o_outputs),
		.o_mem_write(mem_write), .o_mem_write_adr(mem_write_adr),
		.o_mem_write_data(mem_write_data),
		.o_jump(o_jump), .o_jump_offset(jump_offset)
	);

	pat_pc u_pc (
		.clk(clk), .reset(reset),
		.i_jump(o_jump), .i_offset(jump_offset),
		.o_pc(o_pc)
	);

endmodule

// File: tb_pat_core.sv
module tb_pat_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 64; // cycles allowed per wait

	logic                  clk;
	logic                  reset;
	pat_arch_pkg::instr_t  i_instruction;
	pat_arch_pkg::data_t   i_field_in_low;
	pat_arch_pkg::data_t   i_field_in_high;
	pat_arch_pkg::data_t   i_inputs;
	pat_arch_pkg::iaddr_t  o_pc;
	logic                  o_jump;
	pat_arch_pkg::bufp_t   o_bufp;
	pat_arch_pkg::fieldp_t o_fieldp;
	pat_arch_pkg::fieldp_t o_fieldwp;
	logic                  o_field_write_en_low;
	logic                  o_field_write_en_high;
	pat_arch_pkg::data_t   o_field_out;
	pat_arch_pkg::data_t   o_outputs;

	pat_arch_pkg::instr_t prog [1024]; // program of the current run, by pc
	int prog_len;                      // next free slot
	int errors;
	int checks;
	int tests;
	int jumps;                         // o_jump pulses since reset release

	pat_core dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// instruction source, answers the pc 1 ns after the edge
	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			i_instruction <= prog[o_pc];
		end
	end

	// ========================================
	// instruction words
	// ========================================
	function automatic pat_arch_pkg::instr_t i8_word(input logic [1:0] cond, input logic fop,
		input logic [3:0] op, input pat_arch_pkg::data_t imm);
		return {5'd0, cond, fop, op, imm}; // fieldp, cond, field_op, opcode, imm
	endfunction

	function automatic pat_arch_pkg::instr_t i3_word(input logic [3:0] op, input logic [3:0] arg);
		return {5'd0, 2'd0, 1'b0, pat_isa_pkg::PREFIX, op, arg};
	endfunction

	function automatic pat_arch_pkg::instr_t i0_word(input logic fop, input logic [3:0] op);
		return {5'd0, 2'd0, fop, pat_isa_pkg::PREFIX, pat_isa_pkg::PREFIX, op};
	endfunction

	// reference results, 0 or, 1 and, 2 add, 3 sub, 4 not, 5..8 shl shlo shr asr
	function automatic pat_arch_pkg::data_t alu_model(input int op, input pat_arch_pkg::data_t a,
		input pat_arch_pkg::data_t b);
		logic [15:0] wide; // a with its sign copied up, for asr
		int          sh;
		sh = b % 8;       // shifts use the low three bits only
		wide = {{8{a[7]}}, a};
		case (op)
			0:       return a | b;
			1:       return a & b;
			2:       return a + b; // wraps at 256
			3:       return a - b;
			4:       return ~a;
			5:       return a << sh;
			6:       return (a << sh) | (8'hff >> (8 - sh)); // ones shifted in
			7:       return a >> sh;
			default: return 8'(wide >> sh);
		endcase
	endfunction

	task automatic add_instr(input pat_arch_pkg::instr_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// reset goes high and the program is wiped to nops
	task automatic reset_on();
		int a;
		@(posedge clk);
		#1;
		reset <= 1'b1;
		for (a = 0; a < 1024; a++)
			prog[a] = pat_isa_pkg::INSTR_NOP;
		prog_len = 0;
	endtask

	task automatic reset_off();
		repeat (16) @(posedge clk); // 16 cycles in reset
		#1;
		reset <= 1'b0;
		jumps = 0;
	endtask

	// one cycle, outputs looked at on the falling edge
	task automatic step();
		@(negedge clk);
		if (o_jump)
			jumps++;
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report(input string name, input int err_at_start);
		tests++;
		if (errors == err_at_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_at_start);
	endtask

	// ========================================
	// waits, each with its own timeout
	// ========================================
	task automatic wait_pc(input int target, input string name);
		int n;
		n = 0;
		step();
		while (o_pc != target && n < TIMEOUT)
		begin
			step();
			n++;
		end
		if (o_pc != target)
		begin
			$display("%s: pc did not reach %0d in %0d cycles", name, target, TIMEOUT);
			errors++;
		end
	endtask

	task automatic wait_write(input string name);
		int n;
		n = 0;
		step();
		while (!(o_field_write_en_low || o_field_write_en_high) && n < TIMEOUT)
		begin
			step();
			n++;
		end
		if (!(o_field_write_en_low || o_field_write_en_high))
		begin
			$display("%s: no field write enable in %0d cycles", name, TIMEOUT);
			errors++;
		end
	endtask

	// waits for the pulse, then checks the pc one edge later
	task automatic jump_lands(input string name, input pat_arch_pkg::data_t off);
		int                   n;
		pat_arch_pkg::iaddr_t target;
		n = 0;
		step();
		while (!o_jump && n < TIMEOUT)
		begin
			step();
			n++;
		end
		if (!o_jump)
		begin
			$display("%s: o_jump never rose in %0d cycles", name, TIMEOUT);
			errors++;
		end
		target = o_pc + {{2{off[7]}}, off}; // sign extended, wraps at 1024
		step();
		check_eq({name, " target"}, target, o_pc);
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic reset_test();
		int e0;
		e0 = errors;
		reset_on();
		reset_off();
		@(negedge clk); // no edge since release yet
		check_eq("reset pc", 0, o_pc);
		check_eq("reset jump", 0, o_jump);
		check_eq("reset we_low", 0, o_field_write_en_low);
		check_eq("reset we_high", 0, o_field_write_en_high);
		check_eq("reset outputs", 0, o_outputs);
		check_eq("reset bufp", 0, o_bufp);
		report("reset", e0);
	endtask

	task automatic alu_test();
		int                   e0, i;
		pat_arch_pkg::data_t  a, b;
		pat_arch_pkg::instr_t w;
		string                names [9];
		e0 = errors;
		names = '{"or", "and", "add", "sub", "not", "shl", "shlo", "shr", "asr"};
		for (i = 0; i < 9; i++)
		begin
			reset_on();
			a = $urandom;
			b = $urandom;
			case (i)
				0:       w = i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_OR, b);
				1:       w = i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_AND, b);
				2:       w = i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_ADD, b);
				3:       w = i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_SUB, b);
				4:       w = i0_word(1'b0, pat_isa_pkg::OP_NOT);
				5:       w = i3_word(pat_isa_pkg::OP_SHL, {1'b0, b[2:0]});
				6:       w = i3_word(pat_isa_pkg::OP_SHLO, {1'b0, b[2:0]});
				7:       w = i3_word(pat_isa_pkg::OP_SHR, {1'b0, b[2:0]});
				default: w = i3_word(pat_isa_pkg::OP_ASR, {1'b0, b[2:0]});
			endcase
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, a));
			add_instr(w);
			add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0));
			reset_off();
			wait_pc(prog_len + 2, names[i]); // last slot has committed
			check_eq({"alu ", names[i]}, alu_model(i, a, b), o_outputs);
		end
		report("alu", e0);
	endtask

	task automatic mem_test();
		int                   e0, j;
		pat_arch_pkg::data_t  a, m;
		pat_arch_pkg::daddr_t k;
		logic [3:0]           mops [5];
		string                names [5];
		e0 = errors;
		mops = '{pat_isa_pkg::OP_ORM, pat_isa_pkg::OP_ANDM, pat_isa_pkg::OP_ADDM,
			pat_isa_pkg::OP_SUBM, pat_isa_pkg::OP_LDM};
		names = '{"orm", "andm", "addm", "subm", "ldm"};
		reset_on();
		i_inputs <= $urandom;
		add_instr(i3_word(pat_isa_pkg::OP_IN, 4'h0));
		add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0));
		reset_off();
		wait_pc(prog_len + 2, "in");
		check_eq("in out", i_inputs, o_outputs);
		// store m, reload acc with a, then the memory op two slots after the store
		for (j = 0; j < 5; j++)
		begin
			reset_on();
			a = $urandom;
			m = $urandom;
			k = $urandom;
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, m));
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_STM, k));
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, a));
			add_instr(pat_isa_pkg::INSTR_NOP);
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, mops[j], k));
			add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0));
			reset_off();
			wait_pc(prog_len + 2, names[j]);
			check_eq({"mem ", names[j]}, (j == 4) ? m : alu_model(j, a, m), o_outputs);
		end
		report("in and memory", e0);
	endtask

	task automatic field_test();
		int                    e0, side, n;
		pat_arch_pkg::data_t   x;
		pat_arch_pkg::bufp_t   bp;
		pat_arch_pkg::fieldp_t fp;
		pat_arch_pkg::fieldp_t hist [$]; // o_fieldp seen so far
		e0 = errors;
		for (side = 1; side >= 0; side--)
		begin
			reset_on();
			i_field_in_low <= $urandom;
			i_field_in_high <= $urandom;
			x = $urandom;
			bp = $urandom;
			add_instr(i3_word(pat_isa_pkg::OP_SETB, {side[0], bp})); // bit 3 picks high
			add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b1, pat_isa_pkg::OP_ADD, x));
			reset_off();
			wait_write("field add");
			check_eq("field add we_high", side, o_field_write_en_high);
			check_eq("field add we_low", !side, o_field_write_en_low);
			check_eq("field add out",
				8'(x + (side ? i_field_in_high : i_field_in_low)), o_field_out); // mod 256
			check_eq("setb bufp", bp, o_bufp);
		end
		// mov into the field, low side after reset
		reset_on();
		x = $urandom;
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, x));
		add_instr(i0_word(1'b1, pat_isa_pkg::OP_MOV));
		reset_off();
		wait_write("mov");
		check_eq("mov we_low", 1, o_field_write_en_low);
		check_eq("mov out", x, o_field_out);
		reset_on();
		for (n = 0; n < 32; n++)
		begin
			fp = $urandom;
			add_instr({fp, pat_isa_pkg::INSTR_NOP[14:0]}); // nop with its own field pointer
		end
		reset_off();
		for (n = 0; n < 24; n++)
		begin
			step();
			hist.push_back(o_fieldp);
			if (hist.size() > pat_arch_pkg::FIELD_LATENCY)
				check_eq("fieldwp", hist[$ - pat_arch_pkg::FIELD_LATENCY], o_fieldwp);
		end
		report("field", e0);
	endtask

	task automatic branch_test();
		int                  e0, n;
		pat_arch_pkg::data_t off, v;
		e0 = errors;
		off = 8'd4;
		reset_on();
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, 8'h11));
		add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0));
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, 8'h22));
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_BF, off));
		for (n = 0; n < 16; n++)
			add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0)); // shadow and target are all out
		reset_off();
		jump_lands("bf al", off);
		check_eq("bf al flush", 8'h11, o_outputs);
		for (n = 1; n < pat_arch_pkg::FLUSH_LEN; n++)
		begin
			step();
			check_eq("bf al flush", 8'h11, o_outputs);
		end
		step();
		check_eq("bf al resume", 8'h22, o_outputs); // first commit after the flush
		check_eq("bf al pulses", 1, jumps);
		// zero condition on a nonzero acc
		reset_on();
		v = ($urandom % 255) + 1;
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, v));
		add_instr(i0_word(1'b0, pat_isa_pkg::OP_TEST));
		add_instr(i8_word(pat_isa_pkg::COND_Z, 1'b0, pat_isa_pkg::OP_BF, off));
		add_instr(i3_word(pat_isa_pkg::OP_OUT, 4'h0));
		reset_off();
		wait_pc(prog_len + 2, "bf z not taken");
		check_eq("bf z not taken pulses", 0, jumps);
		check_eq("bf z not taken out", v, o_outputs);
		// zero condition on zero
		reset_on();
		add_instr(i8_word(pat_isa_pkg::COND_AL, 1'b0, pat_isa_pkg::OP_LDI, 8'h00));
		add_instr(i0_word(1'b0, pat_isa_pkg::OP_TEST));
		add_instr(i8_word(pat_isa_pkg::COND_Z, 1'b0, pat_isa_pkg::OP_BF, off));
		reset_off();
		jump_lands("bf z taken", off);
		check_eq("bf z taken pulses", 1, jumps);
		report("branch", e0);
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial
	begin
		void'($urandom(59)); // fixed seed for the whole run
		reset = 1'b1;
		i_instruction = pat_isa_pkg::INSTR_NOP;
		i_field_in_low = '0;
		i_field_in_high = '0;
		i_inputs = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		jumps = 0;
		prog_len = 0;
		reset_test();
		alu_test();
		mem_test();
		field_test();
		branch_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: pat_core.f
pat_arch_pkg.sv
pat_isa_pkg.sv
pat_decode_if.sv
pat_alu.sv
pat_data_mem.sv
pat_pc.sv
pat_decode.sv
pat_execute.sv
pat_core.sv
tb_pat_core.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module tb_pat_core -f pat_core.f
	./obj_dir/Vtb_pat_core > sim.log 2>&1; cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
